// File: logic/board_pkg.sv
package board_pkg;

	typedef enum logic [2:0] {
		EMPTY  = 3'o0,
		PAWN   = 3'o1,
		KNIGHT = 3'o2,
		BISHOP = 3'o3,
		ROOK   = 3'o4,
		QUEEN  = 3'o5,
		KING   = 3'o6,
		UNUSED = 3'o7
	} piece_kind_t;

	localparam logic WHITE = 1'b0;
	localparam logic BLACK = 1'b1;

	typedef struct packed {
		logic        colour;
		piece_kind_t kind;
	} square_t;

	localparam int NUM_COLS = 8;

	// square (col, row) sits at row * 8 + col, row 0 is rank 1, col 0 is column a
	typedef square_t [NUM_COLS*NUM_COLS-1:0] board_t;

	function automatic int board_index(int col, int row);
		return row * NUM_COLS + col;
	endfunction

	function automatic logic is_piece(square_t sq, logic colour, piece_kind_t kind);
		return (sq.colour == colour) && (sq.kind == kind);
	endfunction

	// colour bit of an empty square is don't care
	function automatic logic is_empty(square_t sq);
		return sq.kind == EMPTY;
	endfunction

endpackage

// File: logic/move_pkg.sv
package move_pkg;

	// [18:12] flags, [11:6] from square, [5:0] to square
	typedef logic [18:0] move_t;

	// flag bit positions in the move word
	localparam int FLAG_INVALID   = 18;
	localparam int FLAG_PROMOTE   = 17;
	localparam int FLAG_PAWN      = 16;
	localparam int FLAG_PAWN2     = 15;
	localparam int FLAG_ENPASSANT = 14;
	localparam int FLAG_CASTLE    = 13;
	localparam int FLAG_CAPTURE   = 12;

	localparam int FLAGS_LSB = 12;

	localparam logic [6:0] FLAGS_CASTLE = 7'(1 << (FLAG_CASTLE - FLAGS_LSB));

	localparam logic [6:0] FLAGS_ENPASSANT = 7'((1 << (FLAG_PAWN - FLAGS_LSB)) |
		(1 << (FLAG_ENPASSANT - FLAGS_LSB)) |
		(1 << (FLAG_CAPTURE - FLAGS_LSB)));

	// slot 0 kingside, 1 queenside, 2+2c / 3+2c en passant into column c
	localparam int NUM_CAND = 18;

	typedef enum logic [1:0] {
		IDLE,
		SCAN,
		DONE
	} collect_state_t;

	// move words code a square column first, unlike the board index
	function automatic logic [5:0] move_square(int col, int row);
		return 6'(col * 8 + row);
	endfunction

	function automatic move_t make_move(logic [6:0] flags, logic [5:0] from,
		logic [5:0] to);
		return {flags, from, to};
	endfunction

endpackage

// File: logic/castle_check.sv
`timescale 1ns/1ps

module castle_check import board_pkg::*, move_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        start,
	input  board_t      board,
	input  logic        lcas_flag,
	input  logic        rcas_flag,
	output move_t [1:0] cand_move,
	output logic  [1:0] cand_valid
);

	logic king_home;
	logic kside_ok;
	logic qside_ok;

	// no check or attacked-square test, only occupancy and the flags
	assign king_home = is_piece(board[board_index(4, 0)], WHITE, KING); // e1

	assign kside_ok = king_home && rcas_flag &&
		is_piece(board[board_index(7, 0)], WHITE, ROOK) &&
		is_empty(board[board_index(5, 0)]) &&
		is_empty(board[board_index(6, 0)]);

	assign qside_ok = king_home && lcas_flag &&
		is_piece(board[board_index(0, 0)], WHITE, ROOK) &&
		is_empty(board[board_index(1, 0)]) &&
		is_empty(board[board_index(2, 0)]) &&
		is_empty(board[board_index(3, 0)]);

	always_ff @(posedge clk) begin
		if (reset)
			cand_valid <= '0;
		else if (start)
			cand_valid <= {qside_ok, kside_ok};
	end

	always_ff @(posedge clk) begin
		if (start) begin
			cand_move[0] <= make_move(FLAGS_CASTLE, move_square(4, 0), move_square(6, 0)); // e1-g1
			cand_move[1] <= make_move(FLAGS_CASTLE, move_square(4, 0), move_square(2, 0)); // e1-c1
		end
	end

endmodule

// File: logic/enpassant_scan.sv
`timescale 1ns/1ps

module enpassant_scan import board_pkg::*, move_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       start,
	input  board_t                     board,
	input  logic  [NUM_COLS-1:0]       enp_flags,
	output move_t [2*NUM_COLS-1:0]     cand_move,
	output logic  [2*NUM_COLS-1:0]     cand_valid
);

	move_t [2*NUM_COLS-1:0] move_next;
	logic  [2*NUM_COLS-1:0] valid_next;

	// even entry: attacker on the left, odd entry: attacker on the right
	for (genvar c = 0; c < NUM_COLS; c++) begin : g_col
		localparam int LCOL = (c > 0) ? c - 1 : c;
		localparam int RCOL = (c < NUM_COLS - 1) ? c + 1 : c;

		logic victim;
		logic left_pawn;
		logic right_pawn;

		// black pawn that just made its double step onto rank 5
		assign victim = enp_flags[c] && is_piece(board[board_index(c, 4)], BLACK, PAWN);

		assign left_pawn = is_piece(board[board_index(LCOL, 4)], WHITE, PAWN);
		assign right_pawn = is_piece(board[board_index(RCOL, 4)], WHITE, PAWN);

		assign valid_next[2*c] = (c > 0) && victim && left_pawn; // nothing left of column a
		assign valid_next[2*c+1] = (c < NUM_COLS - 1) && victim && right_pawn;

		// capture lands behind the victim on rank 6
		assign move_next[2*c] = make_move(FLAGS_ENPASSANT, move_square(LCOL, 4),
			move_square(c, 5));
		assign move_next[2*c+1] = make_move(FLAGS_ENPASSANT, move_square(RCOL, 4),
			move_square(c, 5));
	end

	always_ff @(posedge clk) begin
		if (reset)
			cand_valid <= '0;
		else if (start)
			cand_valid <= valid_next;
	end

	always_ff @(posedge clk) begin
		if (start)
			cand_move <= move_next;
	end

endmodule

// File: logic/move_fifo.sv
`timescale 1ns/1ps

module move_fifo import move_pkg::*; #(
	parameter int DEPTH = 32
) (
	input  logic  clk,
	input  logic  reset,
	input  logic  clear,
	input  logic  wren,
	input  move_t wdata,
	input  logic  rden,
	output move_t rdata,
	output logic  empty,
	output logic  full
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	move_t         mem [DEPTH];
	logic [AW-1:0] wptr;
	logic [AW-1:0] rptr;
	logic [CW-1:0] count; // occupancy
	logic          do_wr;
	logic          do_rd;

	function automatic logic [AW-1:0] next_ptr(logic [AW-1:0] ptr);
		return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign empty = (count == '0);
	assign full = (count == CW'(DEPTH));
	assign do_wr = wren && !full;
	assign do_rd = rden && !empty; // pop on empty is dropped
	assign rdata = mem[rptr]; // head shows without a read

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wptr] <= wdata;
	end

	always_ff @(posedge clk) begin
		if (reset || clear) begin
			wptr <= '0;
			rptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wptr <= next_ptr(wptr);
			if (do_rd)
				rptr <= next_ptr(rptr);
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

endmodule

// File: logic/move_collector.sv
`timescale 1ns/1ps

module move_collector import move_pkg::*; #(
	parameter int FIFO_DEPTH = 32
) (
	input  logic         clk,
	input  logic         reset,
	input  logic         start,
	input  move_t [1:0]  castle_move,
	input  logic  [1:0]  castle_valid,
	input  move_t [15:0] enp_move,
	input  logic  [15:0] enp_valid,
	input  logic         rden,
	output move_t        move_out,
	output logic         fifo_empty,
	output logic         done
);

	collect_state_t        state;
	logic [4:0]            slot;
	move_t [NUM_CAND-1:0]  slot_move;
	logic  [NUM_CAND-1:0]  slot_valid;
	logic                  fifo_full;
	logic                  fifo_clear;
	logic                  wren;
	logic                  advance;

	// castling first, then en passant by column
	assign slot_move = {enp_move, castle_move};
	assign slot_valid = {enp_valid, castle_valid};

	// a new run throws away whatever the last one left unread
	assign fifo_clear = start && (state != SCAN);

	// an empty slot never waits on a full queue
	assign advance = (state == SCAN) && (!slot_valid[slot] || !fifo_full);
	assign wren = (state == SCAN) && slot_valid[slot] && !fifo_full;

	assign done = (state == DONE);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			slot <= '0;
		end else begin
			case (state)
				SCAN: begin
					if (advance) begin
						if (slot == 5'(NUM_CAND - 1))
							state <= DONE;
						else
							slot <= slot + 5'd1;
					end
				end
				default: begin
					// idle or done, start is ignored while scanning
					if (start) begin
						state <= SCAN;
						slot <= '0;
					end
				end
			endcase
		end
	end

	move_fifo #(
		.DEPTH(FIFO_DEPTH)
	) u_fifo (
		.clk(clk),
		.reset(reset),
		.clear(fifo_clear),
		.wren(wren),
		.wdata(slot_move[slot]),
		.rden(rden),
		.rdata(move_out),
		.empty(fifo_empty),
		.full(fifo_full)
	);

endmodule

// File: logic/special_move_gen.sv
`timescale 1ns/1ps

module special_move_gen import board_pkg::*, move_pkg::*; #(
	parameter int FIFO_DEPTH = 32
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                start,
	input  board_t              board,
	input  logic                lcas_flag,
	input  logic                rcas_flag,
	input  logic [NUM_COLS-1:0] enp_flags,
	input  logic                rden,
	output move_t               move_out,
	output logic                fifo_empty,
	output logic                done
);

	move_t [1:0]            castle_move;
	logic  [1:0]            castle_valid;
	move_t [2*NUM_COLS-1:0] enp_move;
	logic  [2*NUM_COLS-1:0] enp_valid;

	castle_check u_castle (
		.clk(clk),
		.reset(reset),
		.start(start),
		.board(board),
		.lcas_flag(lcas_flag),
		.rcas_flag(rcas_flag),
		.cand_move(castle_move),
		.cand_valid(castle_valid)
	);

	enpassant_scan u_enp (
		.clk(clk),
		.reset(reset),
		.start(start),
		.board(board),
		.enp_flags(enp_flags),
		.cand_move(enp_move),
		.cand_valid(enp_valid)
	);

	// both scanners hold their candidates until the next start
	move_collector #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_collect (
		.clk(clk),
		.reset(reset),
		.start(start),
		.castle_move(castle_move),
		.castle_valid(castle_valid),
		.enp_move(enp_move),
		.enp_valid(enp_valid),
		.rden(rden),
		.move_out(move_out),
		.fifo_empty(fifo_empty),
		.done(done)
	);

endmodule

// File: testbench/special_move_gen_chk.sv
`timescale 1ns/1ps

module special_move_gen_chk import move_pkg::*; (
	input logic  clk,
	input logic  reset,
	input logic  start,
	input logic  rden,
	input move_t move_out,
	input logic  fifo_empty,
	input logic  done
);

	int unsigned failures = 0;

	// done stays low for 18 sampled cycles after start, then shows on the 19th
	property done_latency;
		@(posedge clk) disable iff (reset)
		start |=> !done [*18] ##1 done;
	endproperty

	property empty_in_reset;
		@(posedge clk) reset |=> fifo_empty;
	endproperty

	// head of the queue only moves on a pop or a new run
	property head_stable;
		@(posedge clk) disable iff (reset)
		!fifo_empty && !rden && !start |=> $stable(move_out);
	endproperty

	property done_low_after_reset;
		@(posedge clk) reset |=> !done;
	endproperty

	a_done_latency: assert property (done_latency)
		else begin
			failures++;
			$error("done did not rise 19 cycles after start");
		end

	a_empty_in_reset: assert property (empty_in_reset)
		else begin
			failures++;
			$error("fifo_empty low during reset");
		end

	a_head_stable: assert property (head_stable)
		else begin
			failures++;
			$error("move_out changed without a pop");
		end

	a_done_low_after_reset: assert property (done_low_after_reset)
		else begin
			failures++;
			$error("done high right after reset");
		end

endmodule

bind special_move_gen special_move_gen_chk u_chk (
	.clk(clk),
	.reset(reset),
	.start(start),
	.rden(rden),
	.move_out(move_out),
	.fifo_empty(fifo_empty),
	.done(done)
);

// File: testbench/tb_special_move_gen.sv
`timescale 1ns/1ps

module tb_special_move_gen import board_pkg::*, move_pkg::*; ();

	localparam int FIFO_DEPTH = 32;
	localparam int LATENCY = 19; // cycles from driving start to seeing done
	localparam int NUM_RANDOM = 200;
	localparam int NUM_RUNS = 7 + NUM_RANDOM;
	localparam int WATCHDOG_CYCLES = NUM_RUNS * (40 + FIFO_DEPTH) + 50;
	localparam logic [31:0] SEED = 32'hf4949ef6;

	// flag fields of the move word, invalid bit on the left
	localparam logic [6:0] REF_CASTLE = 7'b0000010;
	localparam logic [6:0] REF_ENPASSANT = 7'b0010101;

	localparam piece_kind_t BACK_RANK [8] = '{ROOK, KNIGHT, BISHOP, QUEEN, KING, BISHOP,
		KNIGHT, ROOK};

	logic         clk;
	logic         reset;
	logic         start;
	board_t       board;
	logic         lcas_flag;
	logic         rcas_flag;
	logic [7:0]   enp_flags;
	logic         rden;
	move_t        move_out;
	logic         fifo_empty;
	logic         done;
	logic [31:0]  rng;
	move_t        expected_q [$];
	move_t        want;

	special_move_gen #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) uut (
		.clk(clk),
		.reset(reset),
		.start(start),
		.board(board),
		.lcas_flag(lcas_flag),
		.rcas_flag(rcas_flag),
		.enp_flags(enp_flags),
		.rden(rden),
		.move_out(move_out),
		.fifo_empty(fifo_empty),
		.done(done)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic square_t piece(input logic colour, input piece_kind_t kind);
		square_t s;
		s.colour = colour;
		s.kind = kind;
		return s;
	endfunction

	// expected moves in slot order, board index row*8+col, move square col*8+row
	function automatic int reference_moves(input board_t b, input logic lf, input logic rf,
		input logic [7:0] ef, output move_t list [NUM_CAND]);
		int n;
		n = 0;
		if (rf && b[4] == piece(WHITE, KING) && b[7] == piece(WHITE, ROOK) &&
			b[5].kind == EMPTY && b[6].kind == EMPTY) begin
			list[n] = {REF_CASTLE, 6'd32, 6'd48}; // e1-g1
			n++;
		end
		if (lf && b[4] == piece(WHITE, KING) && b[0] == piece(WHITE, ROOK) &&
			b[1].kind == EMPTY && b[2].kind == EMPTY && b[3].kind == EMPTY) begin
			list[n] = {REF_CASTLE, 6'd32, 6'd16}; // e1-c1
			n++;
		end
		for (int c = 0; c < 8; c++) begin
			if (ef[c] && b[32 + c] == piece(BLACK, PAWN)) begin
				if (c > 0) begin
					if (b[32 + c - 1] == piece(WHITE, PAWN)) begin
						list[n] = {REF_ENPASSANT, 6'((c - 1) * 8 + 4), 6'(c * 8 + 5)};
						n++;
					end
				end
				if (c < 7) begin
					if (b[32 + c + 1] == piece(WHITE, PAWN)) begin
						list[n] = {REF_ENPASSANT, 6'((c + 1) * 8 + 4), 6'(c * 8 + 5)};
						n++;
					end
				end
			end
		end
		return n;
	endfunction

	task automatic stop_run();
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped on a failure");
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("Error at %0t ns: %s: got 0x%0h, expected 0x%0h", $time, what, actual,
				expected);
			stop_run();
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// the comparing side, every popped head against the front of the expected list
	always @(negedge clk) begin
		if (!reset && rden && !fifo_empty) begin
			if (expected_q.size() == 0) begin
				$display("The queue delivered a move the reference did not expect at %0t ns",
					$time);
				stop_run();
			end else begin
				want = expected_q.pop_front();
				check_value(move_out, want, "move word at the queue head");
			end
		end
	end

	task automatic run_case(input board_t b, input logic lf, input logic rf,
		input logic [7:0] ef, input logic early_read);
		move_t list [NUM_CAND];
		int n;
		int cycles;
		n = reference_moves(b, lf, rf, ef, list);
		check_value(expected_q.size(), 0, "moves left over from the last run");
		for (int i = 0; i < n; i++)
			expected_q.push_back(list[i]);
		board = b;
		lcas_flag = lf;
		rcas_flag = rf;
		enp_flags = ef;
		start = 1'b1;
		next_cycle();
		cycles = 1;
		start = 1'b0;
		if (early_read)
			rden = 1'b1; // pop while the collector is still writing
		while (!done) begin
			next_cycle();
			cycles++;
		end
		check_value(cycles, LATENCY, "cycles from start to done");
		rden = 1'b1;
		while (!fifo_empty)
			next_cycle();
		rden = 1'b0;
		next_cycle();
		check_value(expected_q.size(), 0, "moves never delivered");
		check_value(fifo_empty, 1'b1, "fifo_empty after draining");
		check_value(done, 1'b1, "done held until the next start");
	endtask

	task automatic random_setup(output board_t b, output logic lf, output logic rf,
		output logic [7:0] ef);
		for (int i = 0; i < 64; i++) begin
			rng = xorshift32(rng);
			b[i] = square_t'(rng[3:0]);
		end
		rng = xorshift32(rng);
		if (rng[1:0] != 2'b00)
			b[4] = piece(WHITE, KING);
		if (rng[3:2] != 2'b00)
			b[0] = piece(WHITE, ROOK);
		if (rng[5:4] != 2'b00)
			b[7] = piece(WHITE, ROOK);
		for (int c = 1; c < 7; c++)
			if (c != 4 && rng[8 + 2 * c +: 2] != 2'b00)
				b[c] = piece(WHITE, EMPTY);
		rng = xorshift32(rng);
		for (int c = 0; c < 8; c++) begin
			case (rng[2 * c +: 2])
				2'd0: b[32 + c] = piece(WHITE, PAWN);
				2'd1: b[32 + c] = piece(BLACK, PAWN);
				2'd2: b[32 + c] = piece(WHITE, EMPTY);
				default: ; // keep the random square
			endcase
		end
		rng = xorshift32(rng);
		lf = rng[0];
		rf = rng[1];
		ef = rng[15:8];
	endtask

	initial begin
		board_t b;
		logic lf;
		logic rf;
		logic [7:0] ef;
		reset = 1'b1;
		start = 1'b0;
		board = '0;
		lcas_flag = 1'b0;
		rcas_flag = 1'b0;
		enp_flags = '0;
		rden = 1'b0;
		rng = SEED;
		repeat (10) @(posedge clk);
		#1 reset = 1'b0;
		check_value(done, 1'b0, "done after reset");
		check_value(fifo_empty, 1'b1, "fifo_empty after reset");
		next_cycle();

		b = '0; // opening position, nothing between king and rooks is free
		for (int c = 0; c < 8; c++) begin
			b[c] = piece(WHITE, BACK_RANK[c]);
			b[8 + c] = piece(WHITE, PAWN);
			b[48 + c] = piece(BLACK, PAWN);
			b[56 + c] = piece(BLACK, BACK_RANK[c]);
		end
		run_case(b, 1'b1, 1'b1, 8'h00, 1'b0);

		b = '0;
		b[4] = piece(WHITE, KING);
		b[0] = piece(WHITE, ROOK);
		b[7] = piece(WHITE, ROOK);
		run_case(b, 1'b1, 1'b1, 8'h00, 1'b0);
		run_case(b, 1'b0, 1'b1, 8'h00, 1'b0);
		run_case(b, 1'b1, 1'b0, 8'h00, 1'b0);

		b = '0; // b5, e5 and g5 can be taken, d5 is white and flagged anyway
		b[32 + 0] = piece(WHITE, PAWN);
		b[32 + 1] = piece(BLACK, PAWN);
		b[32 + 2] = piece(WHITE, PAWN);
		b[32 + 3] = piece(WHITE, PAWN);
		b[32 + 4] = piece(BLACK, PAWN);
		b[32 + 5] = piece(WHITE, PAWN);
		b[32 + 6] = piece(BLACK, PAWN);
		run_case(b, 1'b0, 1'b0, 8'b0101_1010, 1'b0);

		// castling and captures together, read out during the scan
		b[4] = piece(WHITE, KING);
		b[0] = piece(WHITE, ROOK);
		b[7] = piece(WHITE, ROOK);
		run_case(b, 1'b1, 1'b1, 8'b0101_1010, 1'b1);

		b = '0; // edge columns only have one neighbour
		b[32 + 0] = piece(BLACK, PAWN);
		b[32 + 1] = piece(WHITE, PAWN);
		b[32 + 6] = piece(WHITE, PAWN);
		b[32 + 7] = piece(BLACK, PAWN);
		run_case(b, 1'b0, 1'b0, 8'hff, 1'b0);

		for (int i = 0; i < NUM_RANDOM; i++) begin
			random_setup(b, lf, rf, ef);
			run_case(b, lf, rf, ef, (i % 4) == 3);
		end

		if (uut.u_chk.failures == 0) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			$display("An assertion in the bound checker failed during the run");
			stop_run();
		end
	end

	initial begin
		wait (uut.u_chk.failures != 0);
		$display("An assertion in the bound checker failed at %0t ns", $time);
		stop_run();
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired before all runs had finished");
		stop_run();
	end

endmodule

// File: special_move_gen.f
logic/board_pkg.sv
logic/move_pkg.sv
logic/castle_check.sv
logic/enpassant_scan.sv
logic/move_fifo.sv
logic/move_collector.sv
logic/special_move_gen.sv
testbench/special_move_gen_chk.sv
testbench/tb_special_move_gen.sv
